//--- compile.f
source/stream_pkg.sv
source/tape_format_pkg.sv
source/byte_link_if.sv
source/cas_reader.sv
source/byte_fifo.sv
source/fsk_modulator.sv
source/cassette_player.sv
tests/credit_link_checker.sv
tests/cassette_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the cassette player testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	--top-module cassette_tb \
	-f compile.f \
	-o cassette_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/cassette_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit 1
fi

exit 0

//--- source/byte_fifo.sv
/*
 * Credit-returning byte FIFO between the reader and the modulator
 */
`default_nettype none

module byte_fifo
	import stream_pkg::*;
(
	input  logic          CLK_VIDEO,
	input  logic          reset,
	input  logic          rewind,
	byte_link_if.receiver in_link,
	byte_link_if.sender   out_link
);

	// Circular buffer of bytes and their last flags
	logic [BYTE_W-1:0]   data_mem [FIFO_DEPTH];
	logic                last_mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0]  wr_ptr;
	logic [FIFO_AW-1:0]  rd_ptr;
	// Fill level, 0..FIFO_DEPTH
	logic [CREDIT_W-1:0] count;
	// Credits held for the modulator link
	logic [CREDIT_W-1:0] out_credits;

	logic                send;

	// Head byte leaves whenever one is stored and a credit is held
	assign send = (count != '0) && (out_credits != '0);

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	// Every valid is accepted, the upstream credit scheme keeps room
	always_ff @(posedge CLK_VIDEO) begin
		if (in_link.valid) begin
			data_mem[wr_ptr] <= in_link.data;
			last_mem[wr_ptr] <= in_link.last;
		end
	end

	//////////////////////////////////////////////////
	// Pointers and counters
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO) begin
		if (reset || rewind) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			out_credits <= CREDIT_W'(MOD_CREDITS);
		end else begin
			if (in_link.valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (send) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Fill level
			case ({in_link.valid, send})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Downstream credits, spent on send, refilled by the modulator
			case ({send, out_link.credit})
				2'b10:   out_credits <= out_credits - 1'b1;
				2'b01:   out_credits <= out_credits + 1'b1;
				default: out_credits <= out_credits;
			endcase
		end
	end

	assign out_link.valid = send;
	assign out_link.data  = data_mem[rd_ptr];
	assign out_link.last  = last_mem[rd_ptr];

	// Slot freed the same cycle the byte leaves
	assign in_link.credit = send;

endmodule

`default_nettype wire

//--- source/byte_link_if.sv
/*
 * Credit-based byte link between stream blocks
 */
`default_nettype none

interface byte_link_if
	import stream_pkg::*;
();

	// Byte present this cycle, receiver must take it
	logic              valid;
	logic [BYTE_W-1:0] data;
	// Final byte of the tape image
	logic              last;
	// Receiver freed one slot this cycle
	logic              credit;

	// Producer side, owns the credit counter
	modport sender (
		output valid,
		output data,
		output last,
		input  credit
	);

	// Consumer side, returns one credit per freed slot
	modport receiver (
		input  valid,
		input  data,
		input  last,
		output credit
	);

endinterface

`default_nettype wire

//--- source/cas_reader.sv
/*
 * Tape image store with host load port, length tracking
 * and a credit-limited two-stage read pump
 */
`default_nettype none

module cas_reader
	import stream_pkg::*;
(
	input  logic               CLK_VIDEO,
	input  logic               reset,
	input  logic               rewind,
	input  logic               play,
	input  logic               load_wr,
	input  logic [LOAD_AW-1:0] load_addr,
	input  logic [BYTE_W-1:0]  load_data,
	byte_link_if.sender        link
);

	// Image bytes
	logic [BYTE_W-1:0]   mem [2**LOAD_AW];

	// One past highest written address
	logic [LOAD_AW:0]    img_len;
	// Next byte to fetch, one bit wider to reach img_len
	logic [LOAD_AW:0]    ptr;
	// Free FIFO slots not yet claimed by a fetch
	logic [CREDIT_W-1:0] credits;
	// Latched on play, keeps prefetching through pauses
	logic                running;

	// Stage 1: registered RAM address
	logic [LOAD_AW-1:0]  rd_addr;
	logic                s1_valid;
	logic                s1_last;
	// Stage 2: RAM output
	logic [BYTE_W-1:0]   rd_data;
	logic                s2_valid;
	logic                s2_last;

	logic                issue;

	// A fetch claims its credit at issue, two reads may be in flight
	assign issue = running && (credits != '0) && (ptr < img_len);

	//////////////////////////////////////////////////
	// Store
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO) begin
		if (load_wr) begin
			mem[load_addr] <= load_data;
		end
		rd_data <= mem[rd_addr];
	end

	// Length grows with the highest address seen, kept over rewind
	always_ff @(posedge CLK_VIDEO) begin
		if (reset) begin
			img_len <= '0;
		end else if (load_wr && ({1'b0, load_addr} >= img_len)) begin
			img_len <= {1'b0, load_addr} + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Read pump
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO) begin
		if (reset || rewind) begin
			ptr      <= '0;
			credits  <= CREDIT_W'(FIFO_DEPTH);
			running  <= 1'b0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (play) begin
				running <= 1'b1;
			end
			if (issue) begin
				ptr <= ptr + 1'b1;
			end
			// Fetch and returned credit in one cycle cancel out
			case ({issue, link.credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			s1_valid <= issue;
			s2_valid <= s1_valid;
		end
	end

	// Address and last flag follow the valid bits down the pipe
	always_ff @(posedge CLK_VIDEO) begin
		rd_addr <= ptr[LOAD_AW-1:0];
		s1_last <= (ptr == img_len - 1'b1);
		s2_last <= s1_last;
	end

	assign link.valid = s2_valid;
	assign link.data  = rd_data;
	assign link.last  = s2_last;

endmodule

`default_nettype wire

//--- source/cassette_player.sv
/*
 * Cassette playback top level, reader to FIFO to modulator
 */
`default_nettype none

module cassette_player
	import stream_pkg::*;
(
	input  logic               CLK_VIDEO,
	input  logic               reset,
	// Host load port, only while stopped
	input  logic               load_wr,
	input  logic [LOAD_AW-1:0] load_addr,
	input  logic [BYTE_W-1:0]  load_data,
	// Transport controls
	input  logic               play,
	input  logic               rewind,
	// Tape audio bit and end of image
	output logic               cas_out,
	output logic               done
);

	// Reader to FIFO
	byte_link_if link_rf ();
	// FIFO to modulator
	byte_link_if link_fm ();

	cas_reader u_reader (
		.CLK_VIDEO (CLK_VIDEO),
		.reset     (reset),
		.rewind    (rewind),
		.play      (play),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.link      (link_rf)
	);

	byte_fifo u_fifo (
		.CLK_VIDEO (CLK_VIDEO),
		.reset     (reset),
		.rewind    (rewind),
		.in_link   (link_rf),
		.out_link  (link_fm)
	);

	fsk_modulator u_mod (
		.CLK_VIDEO (CLK_VIDEO),
		.reset     (reset),
		.rewind    (rewind),
		.play      (play),
		.link      (link_fm),
		.cas_out   (cas_out),
		.done      (done)
	);

endmodule

`default_nettype wire

//--- source/fsk_modulator.sv
/*
 * Byte framing and FSK square-wave generation for the tape output
 */
`default_nettype none

module fsk_modulator
	import stream_pkg::*;
	import tape_format_pkg::*;
(
	input  logic          CLK_VIDEO,
	input  logic          reset,
	input  logic          rewind,
	input  logic          play,
	byte_link_if.receiver link,
	output logic          cas_out,
	output logic          done
);

	mod_state_e           state;

	// One-byte holding register fed by the link
	logic [BYTE_W-1:0]    hold_data;
	logic                 hold_last;
	logic                 hold_full;

	// Byte being framed, LSB goes out first
	logic [BYTE_W-1:0]    shift;
	logic                 frame_last;

	logic                 cur_bit;
	logic                 next_bit;
	logic [BIT_CNT_W-1:0] bit_cnt;
	// Cycles left in the current half-period
	logic [HALF_W-1:0]    half_cnt;
	// Half-period index inside the bit, 0..1 or 0..3
	logic [1:0]           half_num;

	logic                 half_end;
	logic                 bit_end;
	logic                 frame_end;
	logic                 take;

	// Half-period length minus one for a bit value
	function automatic logic [HALF_W-1:0] half_reload(input logic b);
		return b ? HALF_W'(SHORT_HALF - 1) : HALF_W'(LONG_HALF - 1);
	endfunction

	assign half_end  = (state != MOD_IDLE) && (half_cnt == '0);
	// 0 bit is two halves, 1 bit is four, both 2*LONG_HALF cycles
	assign bit_end   = half_end && (half_num == (cur_bit ? 2'd3 : 2'd1));
	assign frame_end = bit_end && (state == MOD_STOP)
		&& (bit_cnt == BIT_CNT_W'(STOP_BITS - 1));

	// New frame from idle or straight after the last stop bit
	assign take = ((state == MOD_IDLE) || frame_end) && play && hold_full;

	// Holding slot frees as the byte moves to the shifter
	assign link.credit = take;

	// Value of the bit after the current one ends
	always_comb begin
		case (state)
			MOD_START: next_bit = shift[0];
			MOD_DATA:  next_bit = (bit_cnt == BIT_CNT_W'(BYTE_W - 1)) ? 1'b1 : shift[1];
			default:   next_bit = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////
	// Holding register and shifter
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO) begin
		if (reset || rewind) begin
			hold_full <= 1'b0;
		end else if (link.valid) begin
			hold_full <= 1'b1;
		end else if (take) begin
			hold_full <= 1'b0;
		end
	end

	always_ff @(posedge CLK_VIDEO) begin
		if (link.valid) begin
			hold_data <= link.data;
			hold_last <= link.last;
		end
		if (take) begin
			shift      <= hold_data;
			frame_last <= hold_last;
		end else if (bit_end && (state == MOD_DATA)) begin
			shift <= shift >> 1;
		end
	end

	//////////////////////////////////////////////////
	// Frame FSM and tone generator
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO) begin
		if (reset || rewind) begin
			state    <= MOD_IDLE;
			cas_out  <= 1'b0;
			done     <= 1'b0;
			cur_bit  <= 1'b0;
			bit_cnt  <= '0;
			half_cnt <= '0;
			half_num <= '0;
		end else begin
			if (frame_end && frame_last) begin
				done <= 1'b1;
			end
			if (take) begin
				// Start bit is a 0, each cycle opens with its high half
				state    <= MOD_START;
				cur_bit  <= 1'b0;
				bit_cnt  <= '0;
				half_num <= '0;
				half_cnt <= half_reload(1'b0);
				cas_out  <= 1'b1;
			end else if (frame_end) begin
				state   <= MOD_IDLE;
				cas_out <= 1'b0;
			end else if (bit_end) begin
				cur_bit  <= next_bit;
				half_num <= '0;
				half_cnt <= half_reload(next_bit);
				cas_out  <= 1'b1;
				case (state)
					MOD_START: begin
						state   <= MOD_DATA;
						bit_cnt <= '0;
					end
					MOD_DATA: begin
						if (bit_cnt == BIT_CNT_W'(BYTE_W - 1)) begin
							state   <= MOD_STOP;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					default: bit_cnt <= bit_cnt + 1'b1;
				endcase
			end else if (half_end) begin
				half_num <= half_num + 1'b1;
				half_cnt <= half_reload(cur_bit);
				cas_out  <= ~cas_out;
			end else if (state != MOD_IDLE) begin
				half_cnt <= half_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/stream_pkg.sv
/*
 * Byte link widths, credit counts and FIFO sizing
 */
`default_nettype none

package stream_pkg;

	//////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////

	// One tape byte per link transfer
	localparam int BYTE_W = 8;
	// Image store address, 1024 bytes
	localparam int LOAD_AW = 10;

	//////////////////////////////////////////////////
	// Flow control
	//////////////////////////////////////////////////

	// FIFO entries, also the reader's starting credit
	localparam int FIFO_DEPTH = 4;
	// FIFO pointers, depth is a power of two so they wrap freely
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	// Modulator holding register slots
	localparam int MOD_CREDITS = 1;
	// Credit counters and FIFO fill level, 0..FIFO_DEPTH
	localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

endpackage

`default_nettype wire

//--- source/tape_format_pkg.sv
/*
 * Cassette framing constants and the FSK modulator state type
 */
`default_nettype none

package tape_format_pkg;

	//////////////////////////////////////////////////
	// FSK tone timing, in CLK_VIDEO cycles
	//////////////////////////////////////////////////

	// Half-period of the 1-bit tone
	localparam int SHORT_HALF = 16;
	// Half-period of the 0-bit tone, always twice the short one
	localparam int LONG_HALF = 2 * SHORT_HALF;
	// Half-period down-counter, must hold LONG_HALF-1
	localparam int HALF_W = $clog2(LONG_HALF);

	//////////////////////////////////////////////////
	// Byte framing
	//////////////////////////////////////////////////

	// Stop bits sent after the data bits
	localparam int STOP_BITS = 2;
	// Bit index inside the data and stop phases (0..7)
	localparam int BIT_CNT_W = 3;

	// Frame phases of the modulator
	typedef enum logic [1:0] {
		MOD_IDLE,
		MOD_START,
		MOD_DATA,
		MOD_STOP
	} mod_state_e;

endpackage

`default_nettype wire

//--- tests/cassette_tb.sv
/*
 * Cassette player testbench: clock, reset, load and transport stimulus,
 * reference bit stream, FSK decoder with comparer, and watchdog
 */
`default_nettype none

module cassette_tb
	import stream_pkg::*;
	import tape_format_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	typedef logic [BYTE_W-1:0] byte_q_t [$];
	typedef bit bit_q_t [$];

	// Start bit, data bits, stop bits
	localparam int FRAME_BITS  = 1 + BYTE_W + STOP_BITS;
	// Every bit lasts two long half-periods
	localparam int BIT_CYCLES  = 2 * LONG_HALF;
	// Bytes played over the whole run, the rewind replays the pause image
	localparam int TOTAL_BYTES = 16 + 64 + 24 + 24;
	localparam int RUN_CYCLES  = TOTAL_BYTES * FRAME_BITS * BIT_CYCLES + 10000;

	logic               CLK_VIDEO;
	logic               reset;
	logic               load_wr;
	logic [LOAD_AW-1:0] load_addr;
	logic [BYTE_W-1:0]  load_data;
	logic               play;
	logic               rewind;
	logic               cas_out;
	logic               done;

	byte_q_t image;
	// Bits still to come from the DUT
	bit_q_t  exp_q;
	int      bits_seen;

	// Decoder state, owned by the comparer
	logic    prev_out;
	int      high_len;
	int      low_len;
	int      last_high;
	bit      short_pend;

	cassette_player DUT (
		.CLK_VIDEO (CLK_VIDEO),
		.reset     (reset),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.play      (play),
		.rewind    (rewind),
		.cas_out   (cas_out),
		.done      (done)
	);

	always #20 CLK_VIDEO = ~CLK_VIDEO;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	// Reference tape stream: start 0, data LSB first, stop bits 1
	function automatic bit_q_t expected_bits(input byte_q_t img);
		bit_q_t bits;
		int     k;
		foreach (img[i]) begin
			bits.push_back(1'b0);
			for (k = 0; k < BYTE_W; k++)
				bits.push_back(img[i][k]);
			for (k = 0; k < STOP_BITS; k++)
				bits.push_back(1'b1);
		end
		return bits;
	endfunction

	//////////////////////////////////////////////////
	// Comparer
	//////////////////////////////////////////////////

	task automatic check_bit(input bit b);
		bit want;
		assert (exp_q.size() != 0) else abort_run("Bit decoded while no bit was expected");
		want = exp_q.pop_front();
		assert (b == want)
			else abort_run($sformatf("FAILED at %0d ns: bit %0d is %0b, expected %0b",
				$time, bits_seen, b, want));
		bits_seen++;
	endtask

	// High half decides the bit, 1 bits come as two short pulses
	task automatic decode_high(input int len);
		assert (len == LONG_HALF || len == SHORT_HALF) else abort_run($sformatf(
			"High half-period of %0d cycles is neither %0d nor %0d", len, SHORT_HALF, LONG_HALF));
		if (len == LONG_HALF) begin
			assert (!short_pend) else abort_run("Long half-period inside a 1 bit");
			check_bit(1'b0);
		end else if (short_pend) begin
			short_pend = 1'b0;
			check_bit(1'b1);
		end else begin
			short_pend = 1'b1;
		end
	endtask

	// Sampled mid-cycle, away from the clock edge that moves cas_out
	always @(negedge CLK_VIDEO) begin
		if (reset) begin
			high_len   = 0;
			low_len    = LONG_HALF;
			last_high  = 0;
			short_pend = 1'b0;
		end else if (cas_out && !prev_out) begin
			// Low gap matches the last high half, longer only between frames
			assert (low_len == last_high
				|| (!short_pend && (bits_seen % FRAME_BITS) == 0 && low_len > last_high))
				else abort_run($sformatf("Low half-period of %0d cycles fits no tone", low_len));
			high_len = 1;
		end else if (cas_out) begin
			high_len++;
		end else if (prev_out) begin
			decode_high(high_len);
			last_high = high_len;
			low_len   = 1;
		end else begin
			low_len++;
		end
		prev_out = cas_out;
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (5) @(posedge CLK_VIDEO);
		reset <= 1'b0;
	endtask

	task automatic wait_bits(input int target);
		int n;
		n = 0;
		while (bits_seen < target) begin
			@(posedge CLK_VIDEO);
			n++;
			assert (n <= FRAME_BITS * BIT_CYCLES * 8) else abort_run("Bit stream stalled");
		end
	endtask

	// Fresh random image, reset, load, then play
	task automatic start_image(input int n);
		image.delete();
		repeat (n) image.push_back(BYTE_W'($urandom()));
		apply_reset();
		foreach (image[i]) begin
			load_wr   <= 1'b1;
			load_addr <= LOAD_AW'(i);
			load_data <= image[i];
			@(posedge CLK_VIDEO);
		end
		load_wr <= 1'b0;
		exp_q = expected_bits(image);
		play  <= 1'b1;
	endtask

	// Wait for done, then the stream must be complete and quiet
	task automatic finish_image();
		int n;
		n = 0;
		while (!done) begin
			@(posedge CLK_VIDEO);
			n++;
			assert (n <= image.size() * FRAME_BITS * BIT_CYCLES + 500)
				else abort_run("done did not rise in time");
		end
		assert (exp_q.size() == 0 && !short_pend)
			else abort_run($sformatf("done rose with %0d bits still expected", exp_q.size()));
		repeat (BIT_CYCLES) begin
			@(posedge CLK_VIDEO);
			assert (!cas_out && done) else abort_run("Output active or done dropped after the end");
		end
		play <= 1'b0;
	endtask

	initial begin
		int base;
		CLK_VIDEO = 1'b0;
		reset     = 1'b1;
		load_wr   = 1'b0;
		load_addr = '0;
		load_data = '0;
		play      = 1'b0;
		rewind    = 1'b0;
		prev_out  = 1'b0;
		bits_seen = 0;
		void'($urandom(32'h45be));
		apply_reset();

		// Empty store, play must not produce anything
		play <= 1'b1;
		repeat (200) begin
			@(posedge CLK_VIDEO);
			assert (!cas_out && !done)
				else abort_run("cas_out or done active with no image loaded");
		end
		play <= 1'b0;

		// Short image, then one longer than the FIFO
		start_image(16);
		finish_image();
		start_image(64);
		finish_image();

		// Pause inside frame 6, modulator ends that frame and holds
		start_image(24);
		base = bits_seen;
		wait_bits(base + 5 * FRAME_BITS + 4);
		play <= 1'b0;
		repeat (2 * FRAME_BITS * BIT_CYCLES) @(posedge CLK_VIDEO);
		assert ((bits_seen - base) == 6 * FRAME_BITS && !cas_out)
			else abort_run("Modulator did not stop at the end of the current frame");
		play <= 1'b1;
		finish_image();

		// Rewind replays the same image from its first byte
		rewind <= 1'b1;
		@(posedge CLK_VIDEO);
		rewind <= 1'b0;
		@(posedge CLK_VIDEO);
		assert (!done) else abort_run("done still high after rewind");
		exp_q = expected_bits(image);
		play <= 1'b1;
		finish_image();

		$display("TEST OK");
		$finish;
	end

	// Watchdog over the whole run
	initial begin
		repeat (RUN_CYCLES) @(posedge CLK_VIDEO);
		abort_run("Watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

//--- tests/credit_link_checker.sv
/*
 * Bound assertions on link credits, receiver fill and modulator idle output
 */
`default_nettype none

module credit_link_checker
	import tape_format_pkg::*;
(
	input logic       CLK_VIDEO,
	input logic       reset,
	input logic       rewind,
	// Credit link into the bound receiver, and its slot count
	input logic       link_valid,
	input logic       link_credit,
	input int         link_capacity,
	// Receiver fill level with its write and read strobes
	input int         fill_count,
	input logic       fill_wr,
	input logic       fill_rd,
	// Modulator frame phase and tone output
	input mod_state_e mod_state,
	input logic       cas_out
);
	timeunit 1ns;
	timeprecision 100ps;

	// Sender credits rebuilt from the link pulses alone
	int sender_credits;

	always_ff @(posedge CLK_VIDEO) begin
		if (reset || rewind) begin
			sender_credits <= link_capacity;
		end else begin
			sender_credits <= sender_credits - int'(link_valid) + int'(link_credit);
		end
	end

	// Each valid spends a credit, so one must be held
	a_valid_has_credit: assert property (
		@(posedge CLK_VIDEO) disable iff (reset)
		link_valid |-> (sender_credits > 0)
	) else $error("Link valid raised with no credit held");

	// Full receiver takes a write only when its head leaves in the same cycle
	a_fifo_no_overflow: assert property (
		@(posedge CLK_VIDEO) disable iff (reset)
		(fill_count <= link_capacity)
			&& !(fill_wr && !fill_rd && (fill_count == link_capacity))
	) else $error("Receiver buffer overflow");

	// No tone between frames
	a_idle_output_low: assert property (
		@(posedge CLK_VIDEO) disable iff (reset)
		(mod_state == MOD_IDLE) |-> !cas_out
	) else $error("cas_out high while the modulator is idle");

endmodule

//////////////////////////////////////////////////
// Attachments
//////////////////////////////////////////////////

// FIFO side, reader link credits and fill level
bind byte_fifo credit_link_checker u_fifo_chk (
	.CLK_VIDEO     (CLK_VIDEO),
	.reset         (reset),
	.rewind        (rewind),
	.link_valid    (in_link.valid),
	.link_credit   (in_link.credit),
	.link_capacity (stream_pkg::FIFO_DEPTH),
	.fill_count    (int'(count)),
	.fill_wr       (in_link.valid),
	.fill_rd       (send),
	.mod_state     (tape_format_pkg::MOD_IDLE),
	.cas_out       (1'b0)
);

// Modulator side, FIFO link credits, holding register and tone output
bind fsk_modulator credit_link_checker u_mod_chk (
	.CLK_VIDEO     (CLK_VIDEO),
	.reset         (reset),
	.rewind        (rewind),
	.link_valid    (link.valid),
	.link_credit   (link.credit),
	.link_capacity (stream_pkg::MOD_CREDITS),
	.fill_count    (int'(hold_full)),
	.fill_wr       (link.valid),
	.fill_rd       (take),
	.mod_state     (state),
	.cas_out       (cas_out)
);

`default_nettype wire
